//--- Bender.yml
package:
  name: exe_unit

sources:
  - hdl/mips_exe_pkg.sv
  - hdl/hilo_reg.sv
  - hdl/div.sv
  - hdl/alu.sv
  - hdl/exe_unit.sv
  - target: test
    files:
      - bench/exe_unit_assertions.sv
      - bench/exe_unit_tb.sv

//--- bench/exe_unit_assertions.sv
`default_nettype none

module exe_unit_assertions import mips_exe_pkg::*; (
	input wire             clk,
	input wire             rst_n,
	input wire             flush,
	input wire             div_busy,
	input wire             div_done,
	input wire div_state_t state
);

	timeunit 1ns;
	timeprecision 1ps;

	// nothing in flight coming out of reset
	a_idle_after_reset: assert property (@(posedge clk) !rst_n |=> !div_busy)
		else $error("divider busy right after reset");

	a_flush_to_idle: assert property (@(posedge clk) disable iff (!rst_n)
		flush |=> state == DIV_IDLE)
		else $error("divider not idle one cycle after flush");

	// result strobe is a single cycle
	a_done_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
		div_done |=> !div_done)
		else $error("div_done held for more than one cycle");

endmodule

bind div exe_unit_assertions i_div_assertions (.*);

`default_nettype wire

//--- bench/exe_unit_tb.sv
`default_nettype none

module exe_unit_tb import mips_exe_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam time CLK_PERIOD  = 40ns;
	localparam int  DIV_TIMEOUT = 100;

	// mask bits in the test file
	localparam int M_OUT   = 0;
	localparam int M_OV    = 1;
	localparam int M_ZERO  = 2;
	localparam int M_HILO  = 3;
	localparam int M_FLUSH = 4;

	logic   clk;
	logic   rst_n;
	logic   flush;
	aluop_t alucontrol;
	word_t  alu_num1;
	word_t  alu_num2;
	shamt_t sa;
	word_t  alu_out;
	logic   overflow;
	logic   zero;
	logic   stall_div;
	dword_t hilo;

	int errors;
	int tests_run;
	int tests_failed;

	exe_unit i_dut (
		.clk        (clk),
		.rst_n      (rst_n),
		.flush      (flush),
		.alucontrol (alucontrol),
		.alu_num1   (alu_num1),
		.alu_num2   (alu_num2),
		.sa         (sa),
		.alu_out    (alu_out),
		.overflow   (overflow),
		.zero       (zero),
		.stall_div  (stall_div),
		.hilo       (hilo)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_dword(input string name, input dword_t got, input dword_t exp);
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	// one instruction, driven on the falling edge
	task automatic run_test(input aluop_t op, input word_t a, input word_t b, input shamt_t s,
			input word_t exp_out, input logic exp_ov, input logic exp_zero,
			input dword_t exp_hilo, input logic [7:0] mask);
		int   err_before;
		int   waited;
		logic is_div;
		err_before = errors;
		is_div     = (op == EXE_DIV_OP) || (op == EXE_DIVU_OP);
		@(negedge clk);
		alucontrol = op;
		alu_num1   = a;
		alu_num2   = b;
		sa         = s;
		#(CLK_PERIOD / 4);
		if (mask[M_OUT])
			check_word("alu_out", alu_out, exp_out);
		if (mask[M_OV])
			check_flag("overflow", overflow, exp_ov);
		if (mask[M_ZERO])
			check_flag("zero", zero, exp_zero);
		if (is_div) begin
			check_flag("stall_div", stall_div, 1'b1);
			if (mask[M_FLUSH]) begin
				// kill the division partway through
				repeat (5) @(negedge clk);
				flush = 1'b1;
				@(negedge clk);
				flush      = 1'b0;
				alucontrol = EXE_NOP_OP;
				#(CLK_PERIOD / 4);
				check_flag("stall_div", stall_div, 1'b0);
			end else begin
				waited = 0;
				do begin
					@(negedge clk);
					waited++;
				end while (stall_div && waited < DIV_TIMEOUT);
				if (stall_div) begin
					$display("timeout: stall_div still high after %0d cycles", DIV_TIMEOUT);
					errors++;
				end else begin
					// 32 iterations, done in the 33rd cycle
					check_word("stall_div cycles", word_t'(waited), word_t'(32));
				end
			end
		end
		@(negedge clk);
		if (mask[M_HILO])
			check_dword("hilo", hilo, exp_hilo);
		alucontrol = EXE_NOP_OP;
		tests_run++;
		if (errors != err_before)
			tests_failed++;
		$display("test %0d op %h %s", tests_run, op, (errors == err_before) ? "ok" : "failed");
	endtask

	initial begin
		int          fd;
		int          n;
		string       line;
		aluop_t      op;
		word_t       a;
		word_t       b;
		shamt_t      s;
		word_t       e_out;
		logic        e_ov;
		logic        e_zero;
		dword_t      e_hilo;
		logic [7:0]  mask;
		word_t       expect_val;
		errors       = 0;
		tests_run    = 0;
		tests_failed = 0;
		void'($urandom(9));
		rst_n        = 1'b0;
		flush        = 1'b0;
		alucontrol   = EXE_NOP_OP;
		alu_num1     = 32'b0;
		alu_num2     = 32'b0;
		sa           = 5'b0;
		repeat (3) @(negedge clk);
		rst_n = 1'b1;

		fd = $fopen("bench/exe_unit_tests.txt", "r");
		if (fd == 0) begin
			$display("could not open bench/exe_unit_tests.txt");
			errors++;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				void'($fgets(line, fd));
				if (line.len() == 0 || line[0] == "#")
					continue;
				n = $sscanf(line, "%h %h %h %h %h %h %h %h %h",
					op, a, b, s, e_out, e_ov, e_zero, e_hilo, mask);
				if (n == 9)
					run_test(op, a, b, s, e_out, e_ov, e_zero, e_hilo, mask);
			end
			$fclose(fd);
		end

		// extra random addu/xor, never overflow
		for (int i = 0; i < 8; i++) begin
			a = $urandom();
			b = $urandom();
			if (i[0]) begin
				expect_val = a ^ b;
				run_test(EXE_XOR_OP, a, b, 5'b0, expect_val, 1'b0, expect_val == 32'b0,
					64'b0, 8'h07);
			end else begin
				expect_val = a + b;
				run_test(EXE_ADDU_OP, a, b, 5'b0, expect_val, 1'b0, expect_val == 32'b0,
					64'b0, 8'h07);
			end
		end

		$display("%0d tests run, %0d passed, %0d failed, %0d check errors",
			tests_run, tests_run - tests_failed, tests_failed, errors);
		if (errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- bench/exe_unit_tests.txt
# opcode num1 num2 sa alu_out overflow zero hilo mask, all hex
# mask bits: 0 alu_out, 1 overflow, 2 zero, 3 hilo, 4 flush during divide
24 f0f0ff00 0ff00ff0 00 00f00f00 0 0 0000000000000000 07
25 f0f0ff00 0ff00ff0 00 fff0fff0 0 0 0000000000000000 07
26 f0f0ff00 0ff00ff0 00 ff00f0f0 0 0 0000000000000000 07
27 12345678 00000000 00 edcba987 0 0 0000000000000000 07
59 ffffffff 1234abcd 00 0000abcd 0 0 0000000000000000 07
5a 12340000 ffff5678 00 12345678 0 0 0000000000000000 07
5b ffff00ff ffff0f0f 00 ffff0ff0 0 0 0000000000000000 07
5c 00000000 0000beef 00 beef0000 0 0 0000000000000000 07
7c 00000000 80000001 04 00000010 0 0 0000000000000000 07
02 00000000 80000010 04 08000001 0 0 0000000000000000 07
03 00000000 80000010 04 f8000001 0 0 0000000000000000 07
04 00000024 00000003 00 00000030 0 0 0000000000000000 07
06 0000001f f0000000 00 00000001 0 0 0000000000000000 07
07 00000008 8000ff00 00 ff8000ff 0 0 0000000000000000 07
20 7fffffff 00000001 00 00000000 1 0 0000000000000000 07
21 7fffffff 00000001 00 80000000 0 0 0000000000000000 07
55 80000000 ffffffff 00 00000000 1 0 0000000000000000 07
56 ffffffff 00000001 00 00000000 0 1 0000000000000000 07
22 80000000 00000001 00 00000000 1 0 0000000000000000 07
23 80000000 00000001 00 7fffffff 0 0 0000000000000000 07
2a ffffffff 00000001 00 00000001 0 0 0000000000000000 07
2b ffffffff 00000001 00 00000000 0 1 0000000000000000 07
57 fffffff0 fffffff8 00 00000001 0 0 0000000000000000 07
58 00000005 fffffff8 00 00000001 0 0 0000000000000000 07
51 00001234 00001234 00 00000000 0 1 0000000000000000 04
52 00001234 00001234 00 00000000 0 0 0000000000000000 04
54 00000001 00000000 00 00000000 0 1 0000000000000000 04
53 00000001 00000000 00 00000000 0 0 0000000000000000 04
40 80000000 00000000 00 00000000 0 1 0000000000000000 04
41 80000000 00000000 00 00000000 0 0 0000000000000000 04
4a 7fffffff 00000000 00 00000000 0 0 0000000000000000 04
4b 00000000 00000000 00 00000000 0 1 0000000000000000 04
18 fffffffe 00000003 00 00000000 0 0 fffffffffffffffa 08
10 00000000 00000000 00 ffffffff 0 0 fffffffffffffffa 09
12 00000000 00000000 00 fffffffa 0 0 fffffffffffffffa 09
19 ffffffff 00000002 00 00000000 0 0 00000001fffffffe 08
11 0000aaaa 00000000 00 00000000 0 0 0000aaaafffffffe 08
13 00005555 00000000 00 00000000 0 0 0000aaaa00005555 08
1a fffffff9 00000002 00 00000000 0 0 fffffffffffffffd 08
1b 00000064 00000007 00 00000000 0 0 000000020000000e 08
1b 12345678 00000000 00 00000000 0 0 12345678ffffffff 08
1a fffffff9 00000000 00 00000000 0 0 fffffff9ffffffff 08
1a 00000064 00000003 00 00000000 0 0 fffffff9ffffffff 18
10 00000000 00000000 00 fffffff9 0 0 fffffff9ffffffff 09
12 00000000 00000000 00 ffffffff 0 0 fffffff9ffffffff 09

//--- exe_unit.f
hdl/mips_exe_pkg.sv
hdl/hilo_reg.sv
hdl/div.sv
hdl/alu.sv
hdl/exe_unit.sv
bench/exe_unit_assertions.sv
bench/exe_unit_tb.sv

//--- hdl/alu.sv
`default_nettype none

module alu import mips_exe_pkg::*; (
	input  wire         clk,
	input  wire         rst_n,
	input  wire         flush,
	input  wire aluop_t alucontrol,
	input  wire word_t  alu_num1,
	input  wire word_t  alu_num2,
	input  wire shamt_t sa,
	input  wire dword_t hilo,
	output word_t       alu_out,
	output logic        overflow,
	output logic        zero,
	output logic        stall_div,
	output logic        hi_we,
	output logic        lo_we,
	output dword_t      hilo_wdata
);

	word_t  alu_ans;
	word_t  sum;
	word_t  diff;
	word_t  imm_zext;
	dword_t mul_signed;
	dword_t mul_unsigned;
	logic   overflow_add;
	logic   overflow_sub;
	logic   div_start;
	logic   div_signed;
	logic   div_busy;
	logic   div_done;
	dword_t div_result;

	assign sum      = alu_num1 + alu_num2;
	assign diff     = alu_num1 - alu_num2;
	assign imm_zext = {16'b0, alu_num2[15:0]};

	// both products are formed at full width
	assign mul_signed   = $signed({{32{alu_num1[31]}}, alu_num1}) *
	                      $signed({{32{alu_num2[31]}}, alu_num2});
	assign mul_unsigned = {32'b0, alu_num1} * {32'b0, alu_num2};

	always_comb begin
		case (alucontrol)
			EXE_AND_OP:    alu_ans = alu_num1 & alu_num2;
			EXE_OR_OP:     alu_ans = alu_num1 | alu_num2;
			EXE_XOR_OP:    alu_ans = alu_num1 ^ alu_num2;
			EXE_NOR_OP:    alu_ans = ~(alu_num1 | alu_num2);
			EXE_ANDI_OP:   alu_ans = alu_num1 & imm_zext;
			EXE_ORI_OP:    alu_ans = alu_num1 | imm_zext;
			EXE_XORI_OP:   alu_ans = alu_num1 ^ imm_zext;
			EXE_LUI_OP:    alu_ans = {alu_num2[15:0], 16'b0};
			// shifts act on num2, variable amount from num1
			EXE_SLL_OP:    alu_ans = alu_num2 << sa;
			EXE_SRL_OP:    alu_ans = alu_num2 >> sa;
			EXE_SRA_OP:    alu_ans = $signed(alu_num2) >>> sa;
			EXE_SLLV_OP:   alu_ans = alu_num2 << alu_num1[4:0];
			EXE_SRLV_OP:   alu_ans = alu_num2 >> alu_num1[4:0];
			EXE_SRAV_OP:   alu_ans = $signed(alu_num2) >>> alu_num1[4:0];
			EXE_MFHI_OP:   alu_ans = hilo[63:32];
			EXE_MFLO_OP:   alu_ans = hilo[31:0];
			EXE_ADD_OP,
			EXE_ADDU_OP,
			EXE_ADDI_OP,
			EXE_ADDIU_OP:  alu_ans = sum;
			EXE_SUB_OP,
			EXE_SUBU_OP:   alu_ans = diff;
			EXE_SLT_OP,
			EXE_SLTI_OP:   alu_ans = {31'b0, $signed(alu_num1) < $signed(alu_num2)};
			EXE_SLTU_OP,
			EXE_SLTIU_OP:  alu_ans = {31'b0, alu_num1 < alu_num2};
			EXE_BEQ_OP,
			EXE_BNE_OP:    alu_ans = diff;
			EXE_J_OP:      alu_ans = sum;
			// effective address
			EXE_LB_OP,
			EXE_LBU_OP,
			EXE_LH_OP,
			EXE_LHU_OP,
			EXE_LW_OP,
			EXE_SB_OP,
			EXE_SH_OP,
			EXE_SW_OP:     alu_ans = sum;
			EXE_MTC0_OP:   alu_ans = alu_num2;
			default:       alu_ans = 32'b0;
		endcase
	end

	// branch decision on zero, otherwise a zero-result flag
	always_comb begin
		case (alucontrol)
			EXE_BEQ_OP:    zero = (alu_num1 == alu_num2);
			EXE_BNE_OP:    zero = (alu_num1 != alu_num2);
			EXE_BGTZ_OP:   zero = !alu_num1[31] && (alu_num1 != 32'b0);
			EXE_BLEZ_OP:   zero = alu_num1[31] || (alu_num1 == 32'b0);
			EXE_BLTZ_OP,
			EXE_BLTZAL_OP: zero = alu_num1[31];
			EXE_BGEZ_OP,
			EXE_BGEZAL_OP: zero = !alu_num1[31];
			default:       zero = (alu_ans == 32'b0);
		endcase
	end

	// signed overflow, trapping forms only
	assign overflow_add = (alucontrol == EXE_ADD_OP || alucontrol == EXE_ADDI_OP) &&
	                      (alu_num1[31] == alu_num2[31]) && (sum[31] != alu_num1[31]);
	assign overflow_sub = (alucontrol == EXE_SUB_OP) &&
	                      (alu_num1[31] != alu_num2[31]) && (diff[31] != alu_num1[31]);
	assign overflow     = overflow_add || overflow_sub;
	assign alu_out      = overflow ? 32'b0 : alu_ans;

	assign div_start  = (alucontrol == EXE_DIV_OP) || (alucontrol == EXE_DIVU_OP);
	assign div_signed = (alucontrol == EXE_DIV_OP);
	assign stall_div  = div_busy;

	div i_div (
		.clk        (clk),
		.rst_n      (rst_n),
		.flush      (flush),
		.div_start  (div_start),
		.div_signed (div_signed),
		.dividend   (alu_num1),
		.divisor    (alu_num2),
		.div_busy   (div_busy),
		.div_done   (div_done),
		.div_result (div_result)
	);

	// hi/lo write select
	always_comb begin
		hi_we      = 1'b0;
		lo_we      = 1'b0;
		hilo_wdata = {alu_num1, alu_num1};
		case (alucontrol)
			EXE_MULT_OP: begin
				hi_we      = 1'b1;
				lo_we      = 1'b1;
				hilo_wdata = mul_signed;
			end
			EXE_MULTU_OP: begin
				hi_we      = 1'b1;
				lo_we      = 1'b1;
				hilo_wdata = mul_unsigned;
			end
			EXE_DIV_OP,
			EXE_DIVU_OP: begin
				hi_we      = div_done;
				lo_we      = div_done;
				hilo_wdata = div_result;
			end
			EXE_MTHI_OP: hi_we = 1'b1;
			EXE_MTLO_OP: lo_we = 1'b1;
			default: begin
				hi_we = 1'b0;
				lo_we = 1'b0;
			end
		endcase
		// killed instruction must not touch hi/lo
		if (flush) begin
			hi_we = 1'b0;
			lo_we = 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- hdl/div.sv
`default_nettype none

module div import mips_exe_pkg::*; (
	input  wire        clk,
	input  wire        rst_n,
	input  wire        flush,
	input  wire        div_start,
	input  wire        div_signed,
	input  wire word_t dividend,
	input  wire word_t divisor,
	output logic       div_busy,
	output logic       div_done,
	output dword_t     div_result
);

	localparam int CNT_W = $clog2(DIV_CYCLES);

	div_state_t       state;
	logic [CNT_W-1:0] count;
	word_t            rem_q;
	word_t            quo_q;
	word_t            dvs_q;
	logic             neg_quo;
	logic             neg_rem;
	word_t            mag_dividend;
	word_t            mag_divisor;
	dword_t           first_step;
	dword_t           next_step;
	logic             load;

	// one restoring step, returns {remainder, quotient}
	function automatic dword_t div_step(input word_t rem, input word_t quo, input word_t dvs);
		logic [32:0] shifted;
		logic [32:0] trial;
		shifted = {rem, quo[31]};
		trial   = shifted - {1'b0, dvs};
		if (!trial[32]) begin
			div_step = {trial[31:0], quo[30:0], 1'b1};
		end else begin
			div_step = {shifted[31:0], quo[30:0], 1'b0};
		end
	endfunction

	assign mag_dividend = (div_signed && dividend[31]) ? -dividend : dividend;
	assign mag_divisor  = (div_signed && divisor[31]) ? -divisor : divisor;

	// first step is folded into the load edge
	assign first_step = div_step(32'b0, mag_dividend, mag_divisor);
	assign next_step  = div_step(rem_q, quo_q, dvs_q);
	assign load       = (state == DIV_IDLE) && div_start && !flush;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= DIV_IDLE;
			count <= '0;
		end else if (flush) begin
			state <= DIV_IDLE;
			count <= '0;
		end else begin
			case (state)
				DIV_IDLE: begin
					if (div_start) begin
						state <= DIV_BUSY;
						count <= CNT_W'(1);
					end
				end
				DIV_BUSY: begin
					count <= count + 1'b1;
					if (count == CNT_W'(DIV_CYCLES - 1)) begin
						state <= DIV_DONE;
					end
				end
				DIV_DONE: state <= DIV_IDLE;
				default:  state <= DIV_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			{rem_q, quo_q} <= first_step;
			dvs_q          <= mag_divisor;
			// divide by zero keeps the quotient at all ones
			neg_quo        <= div_signed && (dividend[31] ^ divisor[31]) &&
			                  (divisor != 32'b0);
			neg_rem        <= div_signed && dividend[31];
		end else if (state == DIV_BUSY) begin
			{rem_q, quo_q} <= next_step;
		end
	end

	assign div_busy   = (state == DIV_BUSY) || load;
	assign div_done   = (state == DIV_DONE);

	// remainder follows the dividend sign
	assign div_result = {neg_rem ? -rem_q : rem_q, neg_quo ? -quo_q : quo_q};

endmodule

`default_nettype wire

//--- hdl/exe_unit.sv
`default_nettype none

module exe_unit import mips_exe_pkg::*; (
	input  wire         clk,
	input  wire         rst_n,
	input  wire         flush,
	input  wire aluop_t alucontrol,
	input  wire word_t  alu_num1,
	input  wire word_t  alu_num2,
	input  wire shamt_t sa,
	output word_t       alu_out,
	output logic        overflow,
	output logic        zero,
	output logic        stall_div,
	output dword_t      hilo
);

	// alu to hi/lo
	logic   hi_we;
	logic   lo_we;
	dword_t hilo_wdata;

	alu i_alu (
		.clk        (clk),
		.rst_n      (rst_n),
		.flush      (flush),
		.alucontrol (alucontrol),
		.alu_num1   (alu_num1),
		.alu_num2   (alu_num2),
		.sa         (sa),
		.hilo       (hilo),
		.alu_out    (alu_out),
		.overflow   (overflow),
		.zero       (zero),
		.stall_div  (stall_div),
		.hi_we      (hi_we),
		.lo_we      (lo_we),
		.hilo_wdata (hilo_wdata)
	);

	// hilo feeds back for mfhi/mflo
	hilo_reg i_hilo_reg (
		.clk        (clk),
		.rst_n      (rst_n),
		.hi_we      (hi_we),
		.lo_we      (lo_we),
		.hilo_wdata (hilo_wdata),
		.hilo       (hilo)
	);

endmodule

`default_nettype wire

//--- hdl/hilo_reg.sv
`default_nettype none

module hilo_reg import mips_exe_pkg::*; (
	input  wire         clk,
	input  wire         rst_n,
	input  wire         hi_we,
	input  wire         lo_we,
	input  wire dword_t hilo_wdata,
	output dword_t      hilo
);

	word_t hi_q;
	word_t lo_q;

	// each half has its own enable
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			hi_q <= 32'b0;
		end else if (hi_we) begin
			hi_q <= hilo_wdata[63:32];
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			lo_q <= 32'b0;
		end else if (lo_we) begin
			lo_q <= hilo_wdata[31:0];
		end
	end

	assign hilo = {hi_q, lo_q};

endmodule

`default_nettype wire

//--- hdl/mips_exe_pkg.sv
`default_nettype none

package mips_exe_pkg;

	// datapath widths
	typedef logic [31:0] word_t;
	typedef logic [63:0] dword_t;
	typedef logic [4:0]  shamt_t;
	typedef logic [7:0]  aluop_t;

	// logic
	localparam aluop_t EXE_AND_OP    = 8'b0010_0100;
	localparam aluop_t EXE_OR_OP     = 8'b0010_0101;
	localparam aluop_t EXE_XOR_OP    = 8'b0010_0110;
	localparam aluop_t EXE_NOR_OP    = 8'b0010_0111;
	localparam aluop_t EXE_ANDI_OP   = 8'b0101_1001;
	localparam aluop_t EXE_ORI_OP    = 8'b0101_1010;
	localparam aluop_t EXE_XORI_OP   = 8'b0101_1011;
	localparam aluop_t EXE_LUI_OP    = 8'b0101_1100;

	// shifts
	localparam aluop_t EXE_SLL_OP    = 8'b0111_1100;
	localparam aluop_t EXE_SRL_OP    = 8'b0000_0010;
	localparam aluop_t EXE_SRA_OP    = 8'b0000_0011;
	localparam aluop_t EXE_SLLV_OP   = 8'b0000_0100;
	localparam aluop_t EXE_SRLV_OP   = 8'b0000_0110;
	localparam aluop_t EXE_SRAV_OP   = 8'b0000_0111;

	// hi/lo moves
	localparam aluop_t EXE_MFHI_OP   = 8'b0001_0000;
	localparam aluop_t EXE_MTHI_OP   = 8'b0001_0001;
	localparam aluop_t EXE_MFLO_OP   = 8'b0001_0010;
	localparam aluop_t EXE_MTLO_OP   = 8'b0001_0011;

	// arithmetic
	localparam aluop_t EXE_ADD_OP    = 8'b0010_0000;
	localparam aluop_t EXE_ADDU_OP   = 8'b0010_0001;
	localparam aluop_t EXE_SUB_OP    = 8'b0010_0010;
	localparam aluop_t EXE_SUBU_OP   = 8'b0010_0011;
	localparam aluop_t EXE_SLT_OP    = 8'b0010_1010;
	localparam aluop_t EXE_SLTU_OP   = 8'b0010_1011;
	localparam aluop_t EXE_ADDI_OP   = 8'b0101_0101;
	localparam aluop_t EXE_ADDIU_OP  = 8'b0101_0110;
	localparam aluop_t EXE_SLTI_OP   = 8'b0101_0111;
	localparam aluop_t EXE_SLTIU_OP  = 8'b0101_1000;
	localparam aluop_t EXE_MULT_OP   = 8'b0001_1000;
	localparam aluop_t EXE_MULTU_OP  = 8'b0001_1001;
	localparam aluop_t EXE_DIV_OP    = 8'b0001_1010;
	localparam aluop_t EXE_DIVU_OP   = 8'b0001_1011;

	// branches and jumps
	localparam aluop_t EXE_J_OP      = 8'b0100_1111;
	localparam aluop_t EXE_BEQ_OP    = 8'b0101_0001;
	localparam aluop_t EXE_BNE_OP    = 8'b0101_0010;
	localparam aluop_t EXE_BGTZ_OP   = 8'b0101_0100;
	localparam aluop_t EXE_BLEZ_OP   = 8'b0101_0011;
	localparam aluop_t EXE_BLTZ_OP   = 8'b0100_0000;
	localparam aluop_t EXE_BGEZ_OP   = 8'b0100_0001;
	localparam aluop_t EXE_BLTZAL_OP = 8'b0100_1010;
	localparam aluop_t EXE_BGEZAL_OP = 8'b0100_1011;

	// memory access, address only
	localparam aluop_t EXE_LB_OP     = 8'b1110_0000;
	localparam aluop_t EXE_LH_OP     = 8'b1110_0001;
	localparam aluop_t EXE_LW_OP     = 8'b1110_0011;
	localparam aluop_t EXE_LBU_OP    = 8'b1110_0100;
	localparam aluop_t EXE_LHU_OP    = 8'b1110_0101;
	localparam aluop_t EXE_SB_OP     = 8'b1110_1000;
	localparam aluop_t EXE_SH_OP     = 8'b1110_1001;
	localparam aluop_t EXE_SW_OP     = 8'b1110_1011;

	// privileged
	localparam aluop_t EXE_MTC0_OP   = 8'b0110_0000;
	localparam aluop_t EXE_ERET_OP   = 8'b0110_1011;
	localparam aluop_t EXE_NOP_OP    = 8'b0000_0000;

	// divider
	typedef enum logic [1:0] {
		DIV_IDLE,
		DIV_BUSY,
		DIV_DONE
	} div_state_t;

	localparam int DIV_CYCLES = 32;

endpackage

`default_nettype wire
